/* verilog/ex_pkg.sv */
package ex_pkg;

    localparam int xlen    = 64;
    localparam int shamt_w = 6;
    localparam int tag_w   = 4;

    // bit 2 selects right shift, bit 0 picks logical over arithmetic
    typedef enum logic [2:0] {
        shift_sll  = 3'b001,
        shift_sllw = 3'b011,
        shift_sra  = 3'b100,
        shift_srl  = 3'b101,
        shift_sraw = 3'b110,
        shift_srlw = 3'b111
    } shift_type_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        shift_type_t      shift_type;
        logic [xlen-1:0]  src;
        logic [xlen-1:0]  shift_num;
    } shift_op_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } shift_res_t;

    // sraw, srlw and sllw work on the low word
    function automatic logic is_word(input shift_type_t shift_type);
        logic right_word;
        logic left_word;
        right_word = (shift_type[2:1] == 2'b11);
        left_word  = ~shift_type[2] & shift_type[1] & shift_type[0];
        return right_word | left_word;
    endfunction

endpackage

/* verilog/ex_shifter.sv */
`timescale 1ns/1ps

module ex_shifter (
    input  ex_pkg::shift_type_t     shift_type,
    input  logic [ex_pkg::xlen-1:0] shifted_data,
    input  logic [ex_pkg::xlen-1:0] shift_num,
    output logic [ex_pkg::xlen-1:0] res_data
);

    logic                       shift_word;
    logic                       shift_sllx;
    logic                       shift_srxx;
    logic                       shift_srax;
    logic                       shift_srlx;
    logic                       shift_srlw;
    logic [ex_pkg::shamt_w-1:0] shift_num_eff;
    logic [ex_pkg::xlen-1:0]    shift_src_pre;
    logic [ex_pkg::xlen-1:0]    shift_src;
    logic [ex_pkg::xlen-1:0]    shift_res;
    logic [ex_pkg::xlen-1:0]    sllx_res;
    logic [ex_pkg::xlen-1:0]    srlx_res;
    logic [ex_pkg::xlen-1:0]    srax_res;
    logic [ex_pkg::xlen-1:0]    sra_mask;
    logic [ex_pkg::xlen-1:0]    sign_fill;

    function automatic logic [ex_pkg::xlen-1:0] reverse_bits(
        input logic [ex_pkg::xlen-1:0] value
    );
        logic [ex_pkg::xlen-1:0] reversed;
        for (int i = 0; i < ex_pkg::xlen; i++) begin
            reversed[i] = value[ex_pkg::xlen-1-i];
        end
        return reversed;
    endfunction

    // ****************************************
    // decode
    // ****************************************
    assign shift_word = ex_pkg::is_word(shift_type);
    assign shift_sllx = ~shift_type[2] & shift_type[0];
    assign shift_srxx = shift_type[2];
    assign shift_srax = shift_srxx & ~shift_type[0];
    assign shift_srlx = shift_srxx & shift_type[0];
    assign shift_srlw = shift_srlx & shift_word;

    assign shift_num_eff = shift_word ? {1'b0, shift_num[4:0]} : shift_num[ex_pkg::shamt_w-1:0];

    // ****************************************
    // one left shifter for all directions
    // ****************************************

    // source arrives word-extended, only srlw by a nonzero amount needs zeros above bit 31
    assign shift_src_pre = (shift_srlw && (shift_num_eff != '0)) ?
                           {32'b0, shifted_data[31:0]} : shifted_data;

    // right shifts run through the left shifter mirrored
    assign shift_src = shift_srxx ? reverse_bits(shift_src_pre) : shift_src_pre;
    assign shift_res = shift_src << shift_num_eff;

    assign sllx_res = shift_res;
    assign srlx_res = reverse_bits(shift_res);

    // mask marks the bits that came from the source, the rest take the sign
    assign sra_mask  = {ex_pkg::xlen{1'b1}} >> shift_num_eff;
    assign sign_fill = {ex_pkg::xlen{shift_src_pre[ex_pkg::xlen-1]}} & ~sra_mask;

    assign srax_res = (srlx_res & sra_mask) | sign_fill;

    assign res_data = ({ex_pkg::xlen{shift_sllx}} & sllx_res)
                    | ({ex_pkg::xlen{shift_srax}} & srax_res)
                    | ({ex_pkg::xlen{shift_srlx}} & srlx_res);

endmodule

/* verilog/ex_op_queue.sv */
`timescale 1ns/1ps

module ex_op_queue #(
    parameter int op_queue_depth = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  ex_pkg::shift_op_t push_op,
    input  logic              pop_enable,
    output logic              pop_valid,
    output ex_pkg::shift_op_t pop_op,
    output logic              op_credit
);

    localparam int ptr_w   = (op_queue_depth > 1) ? $clog2(op_queue_depth) : 1;
    localparam int count_w = $clog2(op_queue_depth + 1);

    ex_pkg::shift_op_t  mem [op_queue_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               wr_en;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(op_queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // issue side never pushes without a credit, full only guards the memory
    assign wr_en     = push && (count != count_w'(op_queue_depth));
    assign pop_valid = (count != '0) && pop_enable;
    assign pop_op    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            op_credit <= 1'b0;
        end else begin
            op_credit <= pop_valid;
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, pop_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/ex_credit_counter.sv */
`timescale 1ns/1ps

module ex_credit_counter #(
    parameter int wb_credits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic consume,
    input  logic credit_return,
    output logic available
);

    localparam int count_w = $clog2(wb_credits + 1);

    // free writeback slots, a slot is taken when its op leaves the queue
    logic [count_w-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= count_w'(wb_credits);
        end else begin
            case ({consume, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign available = (count != '0);

endmodule

/* verilog/ex_operand_stage.sv */
`timescale 1ns/1ps

module ex_operand_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  ex_pkg::shift_op_t in_op,
    output logic              out_valid,
    output ex_pkg::shift_op_t out_op
);

    ex_pkg::shift_op_t ext_op;

    // word ops enter the shifter with bit 31 copied upwards
    always_comb begin
        ext_op = in_op;
        if (ex_pkg::is_word(in_op.shift_type)) begin
            ext_op.src = {{32{in_op.src[31]}}, in_op.src[31:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_op <= ext_op;
        end
    end

endmodule

/* verilog/ex_result_stage.sv */
`timescale 1ns/1ps

module ex_result_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  ex_pkg::shift_op_t  in_op,
    output logic               res_valid,
    output ex_pkg::shift_res_t res
);

    logic [ex_pkg::xlen-1:0] shift_data;
    logic [ex_pkg::xlen-1:0] final_data;

    ex_shifter ex_shifter_i (
        .shift_type   (in_op.shift_type),
        .shifted_data (in_op.src),
        .shift_num    (in_op.shift_num),
        .res_data     (shift_data)
    );

    // shifter leaves the upper word of w results undefined
    assign final_data = ex_pkg::is_word(in_op.shift_type) ?
                        {{32{shift_data[31]}}, shift_data[31:0]} : shift_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            res.tag  <= in_op.tag;
            res.data <= final_data;
        end
    end

endmodule

/* verilog/ex_shift_unit.sv */
`timescale 1ns/1ps

module ex_shift_unit #(
    parameter int op_queue_depth = 4,
    parameter int wb_credits     = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_valid,
    input  ex_pkg::shift_op_t  op,
    output logic               op_credit,
    output logic               res_valid,
    output ex_pkg::shift_res_t res,
    input  logic               res_credit
);

    logic              wb_available;
    logic              pop_valid;
    ex_pkg::shift_op_t pop_op;
    logic              stage_valid;
    ex_pkg::shift_op_t stage_op;

    // ****************************************
    // flow control
    // ****************************************
    ex_op_queue #(
        .op_queue_depth (op_queue_depth)
    ) ex_op_queue_i (
        .clk        (clk),
        .reset      (reset),
        .push       (op_valid),
        .push_op    (op),
        .pop_enable (wb_available),
        .pop_valid  (pop_valid),
        .pop_op     (pop_op),
        .op_credit  (op_credit)
    );

    // a pop reserves its writeback slot, so the stages never stall
    ex_credit_counter #(
        .wb_credits (wb_credits)
    ) ex_credit_counter_i (
        .clk           (clk),
        .reset         (reset),
        .consume       (pop_valid),
        .credit_return (res_credit),
        .available     (wb_available)
    );

    // ****************************************
    // pipeline
    // ****************************************
    ex_operand_stage ex_operand_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pop_valid),
        .in_op     (pop_op),
        .out_valid (stage_valid),
        .out_op    (stage_op)
    );

    ex_result_stage ex_result_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (stage_valid),
        .in_op     (stage_op),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

/* sim/ex_shift_ref.svh */
`ifndef EX_SHIFT_REF_SVH
`define EX_SHIFT_REF_SVH

// row columns: shift type, source, shift amount register, expected data
typedef struct packed {
    ex_pkg::shift_type_t shift_type;
    logic [63:0]         src;
    logic [63:0]         shift_num;
    logic [63:0]         data;
} ref_row_t;

ref_row_t ref_rows [$];

// 64-bit ops shift by 6 bits, word ops shift the low word by 5 and sign-extend it
function automatic logic [63:0] shift_model(
    input ex_pkg::shift_type_t shift_type,
    input logic [63:0]         src,
    input logic [63:0]         shift_num
);
    logic [63:0] full;
    logic [31:0] word;
    full = '0;
    word = '0;
    case (shift_type)
        ex_pkg::shift_sll:  full = src << shift_num[5:0];
        ex_pkg::shift_srl:  full = src >> shift_num[5:0];
        ex_pkg::shift_sra:  full = $signed(src) >>> shift_num[5:0];
        ex_pkg::shift_sllw: word = src[31:0] << shift_num[4:0];
        ex_pkg::shift_srlw: word = src[31:0] >> shift_num[4:0];
        default:            word = $signed(src[31:0]) >>> shift_num[4:0];
    endcase
    if ((shift_type == ex_pkg::shift_sllw) || (shift_type == ex_pkg::shift_srlw) ||
        (shift_type == ex_pkg::shift_sraw)) begin
        full = {{32{word[31]}}, word};
    end
    return full;
endfunction

task automatic add_row(
    input ex_pkg::shift_type_t shift_type,
    input logic [63:0]         src,
    input logic [63:0]         shift_num,
    input logic [63:0]         data
);
    ref_rows.push_back('{shift_type, src, shift_num, data});
endtask

task automatic fill_table();
    logic [63:0]         sweep_src [2];
    int                  sweep_amt [5];
    logic [63:0]         num;
    ex_pkg::shift_type_t t;
    sweep_src = '{64'hf0e1_d2c3_b4a5_9687, 64'h0f1e_2d3c_4b5a_6978};
    sweep_amt = '{0, 1, 31, 32, 63};
    add_row(ex_pkg::shift_sll,  64'h0000_0000_0000_0001, 64'd63, 64'h8000_0000_0000_0000);
    add_row(ex_pkg::shift_sll,  64'h8123_4567_89ab_cdef, 64'd0,  64'h8123_4567_89ab_cdef);
    add_row(ex_pkg::shift_srl,  64'h8000_0000_0000_0000, 64'd63, 64'h0000_0000_0000_0001);
    add_row(ex_pkg::shift_srl,  64'h8000_0000_0000_0000, 64'd32, 64'h0000_0000_8000_0000);
    add_row(ex_pkg::shift_sra,  64'h8000_0000_0000_0000, 64'd63, 64'hffff_ffff_ffff_ffff);
    add_row(ex_pkg::shift_sra,  64'h8000_0000_0000_0000, 64'd31, 64'hffff_ffff_0000_0000);
    add_row(ex_pkg::shift_sra,  64'h4000_0000_0000_0000, 64'd1,  64'h2000_0000_0000_0000);
    add_row(ex_pkg::shift_sllw, 64'h0000_0000_0000_0001, 64'd31, 64'hffff_ffff_8000_0000);
    add_row(ex_pkg::shift_sllw, 64'hffff_ffff_0000_0001, 64'd32, 64'h0000_0000_0000_0001);
    add_row(ex_pkg::shift_srlw, 64'hffff_ffff_8000_0000, 64'd0,  64'hffff_ffff_8000_0000);
    add_row(ex_pkg::shift_srlw, 64'h0000_0000_8000_0000, 64'd1,  64'h0000_0000_4000_0000);
    add_row(ex_pkg::shift_sraw, 64'h0000_0000_8000_0000, 64'd1,  64'hffff_ffff_c000_0000);
    add_row(ex_pkg::shift_sraw, 64'h0000_0000_8000_0000, 64'd63, 64'hffff_ffff_ffff_ffff);
    add_row(ex_pkg::shift_sraw, 64'h7fff_ffff_7fff_ffff, 64'd31, 64'h0000_0000_0000_0000);
    // every type against every amount and both signs
    t = t.first();
    repeat (6) begin
        foreach (sweep_amt[a]) begin
            foreach (sweep_src[s]) begin
                num = 64'(sweep_amt[a]);
                add_row(t, sweep_src[s], num, shift_model(t, sweep_src[s], num));
            end
        end
        t = t.next();
    end
endtask

`endif

/* sim/tb_ex_shift_unit.sv */
`timescale 1ns/1ps

module tb_ex_shift_unit;

    localparam int op_queue_depth = 4;
    localparam int wb_credits     = 2;
    localparam int clk_period     = 4;
    localparam int extra_ops      = 24;

    logic               clk;
    logic               reset;
    logic               op_valid;
    ex_pkg::shift_op_t  op;
    logic               op_credit;
    logic               res_valid;
    ex_pkg::shift_res_t res;
    logic               res_credit;

    ex_pkg::shift_res_t expected_q [$];
    int                 credit_due_q [$];
    int                 cycle;
    int                 issue_credits;
    int                 ops_sent;
    int                 credit_pulses;
    int                 results_seen;
    logic               withhold;

    `include "ex_shift_ref.svh"

    ex_shift_unit #(
        .op_queue_depth (op_queue_depth),
        .wb_credits     (wb_credits)
    ) ex_shift_unit_i (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .op         (op),
        .op_credit  (op_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_res(input ex_pkg::shift_res_t got, input ex_pkg::shift_res_t exp);
        if (got.tag !== exp.tag) begin
            fail_run($sformatf("ERROR res.tag got %h exp %h", got.tag, exp.tag));
        end else if (got.data !== exp.data) begin
            fail_run($sformatf("ERROR res.data got %h exp %h", got.data, exp.data));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("ERROR %s got %h exp %h", name, got, exp));
        end
    endtask

    // ****************************************
    // one falling edge: outputs, writeback model, issue credits
    // ****************************************
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        op_valid   = 1'b0;
        res_credit = 1'b0;
        if (!reset) begin
            if (ops_sent == 0) begin
                check_count("op_credit", op_credit, 0);
                check_count("res_valid", res_valid, 0);
            end
            if (op_credit) begin
                issue_credits++;
                credit_pulses++;
            end
            if (res_valid) begin
                if (expected_q.size() == 0) begin
                    fail_run("a result appeared with no operation outstanding");
                end else begin
                    check_res(res, expected_q.pop_front());
                    results_seen++;
                    credit_due_q.push_back(cycle + $urandom_range(3));
                end
            end
            // slot freed some cycles after the result, one pulse per cycle
            if (!withhold && credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
                void'(credit_due_q.pop_front());
                res_credit = 1'b1;
            end
        end
    endtask

    task automatic send_op(input logic [ex_pkg::tag_w-1:0] tag, input ref_row_t row);
        while (issue_credits == 0) begin
            next_cycle();
        end
        op       = '{tag, row.shift_type, row.src, row.shift_num};
        op_valid = 1'b1;
        issue_credits--;
        ops_sent++;
        expected_q.push_back('{tag, row.data});
    endtask

    task automatic drain();
        while (results_seen < ops_sent || credit_due_q.size() > 0) begin
            next_cycle();
        end
    endtask

    function automatic ref_row_t random_row();
        ref_row_t row;
        row.shift_type = ref_rows[$urandom_range(ref_rows.size() - 1)].shift_type;
        row.src        = {$urandom, $urandom};
        row.shift_num  = {$urandom, $urandom};
        row.data       = shift_model(row.shift_type, row.src, row.shift_num);
        return row;
    endfunction

    initial begin
        wait (ref_rows.size() > 0);
        #((ref_rows.size() + extra_ops) * 40 * clk_period);
        fail_run("watchdog expired before the tests completed");
    end

    initial begin
        int latency;
        int sent_before;
        int pulses_before;
        int results_before;
        int idle;
        void'($urandom(32'h383f_401c));
        clk           = 1'b0;
        reset         = 1'b1;
        op_valid      = 1'b0;
        op            = '0;
        res_credit    = 1'b0;
        withhold      = 1'b0;
        cycle         = 0;
        issue_credits = op_queue_depth;
        ops_sent      = 0;
        credit_pulses = 0;
        results_seen  = 0;
        fill_table();
        repeat (8) next_cycle();
        reset = 1'b0;
        repeat (4) next_cycle();

        // lone op into the idle unit
        send_op(4'd0, ref_rows[0]);
        latency = 0;
        do begin
            next_cycle();
            latency++;
        end while (!res_valid && latency < 8);
        check_count("res_valid latency", latency, 3);

        foreach (ref_rows[i]) begin
            repeat ($urandom_range(2)) next_cycle();
            next_cycle();
            send_op(4'(i % 16), ref_rows[i]);
        end
        drain();

        // ****************************************
        // writeback credits withheld
        // ****************************************
        withhold       = 1'b1;
        sent_before    = ops_sent;
        pulses_before  = credit_pulses;
        results_before = results_seen;
        idle           = 0;
        while (idle < 12) begin
            next_cycle();
            if (issue_credits > 0 && ops_sent - sent_before < extra_ops) begin
                send_op(4'(ops_sent % 16), random_row());
                idle = 0;
            end else begin
                idle++;
            end
        end
        check_count("results while withheld", results_seen - results_before, wb_credits);
        check_count("op_credit while withheld", credit_pulses - pulses_before, wb_credits);
        check_count("ops while withheld", ops_sent - sent_before, op_queue_depth + wb_credits);
        withhold = 1'b0;
        drain();
        repeat (4) next_cycle();
        check_count("op_credit pulses", credit_pulses, ops_sent);
        check_count("issue credits", issue_credits, op_queue_depth);

        if (expected_q.size() == 0 && results_seen == ops_sent) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("results still missing at the end of the run");
        end
    end

endmodule

/* ex_shift_unit.f */
+incdir+sim
verilog/ex_pkg.sv
verilog/ex_shifter.sv
verilog/ex_op_queue.sv
verilog/ex_credit_counter.sv
verilog/ex_operand_stage.sv
verilog/ex_result_stage.sv
verilog/ex_shift_unit.sv
sim/tb_ex_shift_unit.sv
